// ==== hdl/t0_decode_pkg.sv ====
package t0_decode_pkg;

    // ------------------------------
    // ML-DSA sizes
    // ------------------------------

    // Width of one packed t0 field in the secret key
    localparam int mldsa_d = 13;

    // Width of one decoded coefficient as stored downstream
    localparam int reg_size = 24;

    // ML-DSA modulus q = 2^23 - 2^13 + 1
    localparam logic [reg_size-1:0] mldsa_q = reg_size'(8380417);

    // One input word carries two t0 fields side by side
    localparam int pair_width = 2 * mldsa_d;

    // A 256-coefficient polynomial leaves the decoder as 128 pairs
    localparam int coeff_pairs = 128;

    // Pair address width, 7 bits for 128 pairs
    localparam int pair_addr_w = $clog2(coeff_pairs);

    // ------------------------------
    // Input word views
    // ------------------------------

    // Field view of one input word; the upper field feeds lane 1
    typedef struct packed {
        logic [mldsa_d-1:0] field_hi;
        logic [mldsa_d-1:0] field_lo;
    } t0_fields_t;

    // The same word either as it arrives on the port or split into fields
    typedef union packed {
        logic [pair_width-1:0] raw;
        t0_fields_t            fields;
    } t0_word_u;

endpackage

// ==== hdl/t0_unpack.sv ====
`timescale 1ns/10ps

// One t0 decode lane
// Sub mode gives (2^(d-1) - field) mod q and add mode gives (2^(d-1) + field) mod q
module t0_unpack (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  logic                                enable_i,
    input  logic                                sub_i,
    input  logic [t0_decode_pkg::mldsa_d-1:0]   field_i,
    output logic [t0_decode_pkg::reg_size-1:0]  coeff_o,
    output logic                                valid_o
);
    import t0_decode_pkg::*;

    // Stage one operands and result
    logic [reg_size-1:0] half_d;
    logic [reg_size-1:0] field_ext;
    logic [reg_size-1:0] opb0;
    logic [reg_size:0]   sum0;

    // Stage one registers
    logic [reg_size-1:0] r0_q;
    logic                carry0_q;
    logic                sub_q;
    logic                valid_q;

    // Stage two operands and result
    logic [reg_size-1:0] opb1;
    logic [reg_size:0]   sum1;
    logic                carry1;
    logic                use_corr;

    // ------------------------------
    // Stage one
    // ------------------------------

    // Constant offset 2^(d-1), which is 4096 for d = 13
    assign half_d = reg_size'(1) << (mldsa_d - 1);

    // Field widened to coefficient size before the optional inversion
    assign field_ext = {{(reg_size - mldsa_d){1'b0}}, field_i};

    // Subtraction is done as offset + ~field + 1 over the full 24 bits
    assign opb0 = sub_i ? ~field_ext : field_ext;

    // Carry out is set in sub mode when offset >= field (no borrow)
    // In add mode the sum stays far below 2^24 so the carry is always clear
    assign sum0 = {1'b0, half_d} + {1'b0, opb0} + {{reg_size{1'b0}}, sub_i};

    // Sum, carry and mode are captured together so stage two sees one word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r0_q     <= '0;
            carry0_q <= 1'b0;
            sub_q    <= 1'b0;
        end else if (zeroize_i) begin
            r0_q     <= '0;
            carry0_q <= 1'b0;
            sub_q    <= 1'b0;
        end else if (enable_i) begin
            r0_q     <= sum0[reg_size-1:0];
            carry0_q <= sum0[reg_size];
            sub_q    <= sub_i;
        end
    end

    // Valid follows the enable by one edge and is dropped on zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else if (zeroize_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= enable_i;
        end
    end

    // ------------------------------
    // Stage two
    // ------------------------------

    // Sub mode adds q back to a negative result
    // Add mode subtracts q as r0 + ~q + 1
    assign opb1 = sub_q ? mldsa_q : ~mldsa_q;

    assign sum1 = {1'b0, r0_q} + {1'b0, opb1} + {{reg_size{1'b0}}, ~sub_q};

    assign carry1 = sum1[reg_size];

    // A missing stage-one carry in sub mode means the difference went negative
    // In add mode a stage-two carry means r0 >= q and the reduced value is taken
    // Stage-one carry is clear in add mode, so the xor reduces to carry1 there
    assign use_corr = sub_q ? ~carry0_q : (carry0_q ^ carry1);

    // Result lies in 0 .. q-1 and is formed straight from the stage-one registers
    assign coeff_o = use_corr ? sum1[reg_size-1:0] : r0_q;

    assign valid_o = valid_q;

endmodule

// ==== hdl/coeff_pair_pack.sv ====
`timescale 1ns/10ps

// Packs two lane results into one output word and tags it with its pair address
// Last pair of every polynomial raises poly_done_o with valid_o
module coeff_pair_pack (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    zeroize_i,
    input  logic [t0_decode_pkg::reg_size-1:0]      coeff_lo_i,
    input  logic [t0_decode_pkg::reg_size-1:0]      coeff_hi_i,
    input  logic                                    valid_lo_i,
    input  logic                                    valid_hi_i,
    output logic [2*t0_decode_pkg::reg_size-1:0]    pair_o,
    output logic [t0_decode_pkg::pair_addr_w-1:0]   addr_o,
    output logic                                    valid_o,
    output logic                                    poly_done_o
);
    import t0_decode_pkg::*;

    // Both lanes run in lockstep, so a pair is taken only when both are valid
    logic                      take_pair;

    // Address the next accepted pair will carry
    logic [pair_addr_w-1:0]    next_addr;
    logic                      last_pair;

    // Output registers
    logic [2*reg_size-1:0]     pair_q;
    logic [pair_addr_w-1:0]    addr_q;
    logic                      valid_q;
    logic                      poly_done_q;

    assign take_pair = valid_lo_i & valid_hi_i;

    // Pair 127 closes a polynomial
    assign last_pair = (next_addr == pair_addr_w'(coeff_pairs - 1));

    // ------------------------------
    // Pair counter
    // ------------------------------

    // Counts accepted pairs and wraps from 127 to 0 on its own width
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            next_addr <= '0;
        end else if (zeroize_i) begin
            next_addr <= '0;
        end else if (take_pair) begin
            next_addr <= next_addr + 1'b1;
        end
    end

    // ------------------------------
    // Output stage
    // ------------------------------

    // Lane 1 goes to the upper half, lane 0 to the lower half
    // Address holds its last value between outputs
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pair_q <= '0;
            addr_q <= '0;
        end else if (zeroize_i) begin
            pair_q <= '0;
            addr_q <= '0;
        end else if (take_pair) begin
            pair_q <= {coeff_hi_i, coeff_lo_i};
            addr_q <= next_addr;
        end
    end

    // Strobes last one cycle per accepted pair
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q     <= 1'b0;
            poly_done_q <= 1'b0;
        end else if (zeroize_i) begin
            valid_q     <= 1'b0;
            poly_done_q <= 1'b0;
        end else begin
            valid_q     <= take_pair;
            poly_done_q <= take_pair & last_pair;
        end
    end

    assign pair_o      = pair_q;
    assign addr_o      = addr_q;
    assign valid_o     = valid_q;
    assign poly_done_o = poly_done_q;

endmodule

// ==== hdl/skdecode_t0.sv ====
`timescale 1ns/10ps

// t0 unpack stage of the secret-key decoder
// Two decode lanes work on the two fields of one word, then the packer joins them
// Total latency from valid_i to valid_o is two edges
module skdecode_t0 (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    zeroize_i,
    input  logic                                    valid_i,
    input  logic                                    sub_i,
    input  logic [t0_decode_pkg::pair_width-1:0]    word_i,
    output logic [2*t0_decode_pkg::reg_size-1:0]    pair_o,
    output logic [t0_decode_pkg::pair_addr_w-1:0]   addr_o,
    output logic                                    valid_o,
    output logic                                    poly_done_o
);
    import t0_decode_pkg::*;

    // Field view of the incoming word
    t0_word_u            word_u;

    // Lane results towards the packer
    logic [reg_size-1:0] coeff_lo;
    logic [reg_size-1:0] coeff_hi;
    logic                valid_lo;
    logic                valid_hi;

    assign word_u.raw = word_i;

    // ------------------------------
    // Decode lanes
    // ------------------------------

    // Lane 0 takes the lower field
    t0_unpack t0_unpack_lo_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (valid_i),
        .sub_i     (sub_i),
        .field_i   (word_u.fields.field_lo),
        .coeff_o   (coeff_lo),
        .valid_o   (valid_lo)
    );

    // Lane 1 takes the upper field with the same mode and strobe
    t0_unpack t0_unpack_hi_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (valid_i),
        .sub_i     (sub_i),
        .field_i   (word_u.fields.field_hi),
        .coeff_o   (coeff_hi),
        .valid_o   (valid_hi)
    );

    // ------------------------------
    // Pair packer
    // ------------------------------

    coeff_pair_pack coeff_pair_pack_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .coeff_lo_i  (coeff_lo),
        .coeff_hi_i  (coeff_hi),
        .valid_lo_i  (valid_lo),
        .valid_hi_i  (valid_hi),
        .pair_o      (pair_o),
        .addr_o      (addr_o),
        .valid_o     (valid_o),
        .poly_done_o (poly_done_o)
    );

endmodule

// ==== verif/skdecode_t0_chk.sv ====
`timescale 1ns/10ps

// Assertion checker for the t0 decoder that is bound to skdecode_t0
// Expected values come from the input ports two edges back and the t0 decoding rule
module skdecode_t0_chk (
    input logic                                    clk,
    input logic                                    reset_n,
    input logic                                    zeroize_i,
    input logic                                    valid_i,
    input logic                                    sub_i,
    input logic [t0_decode_pkg::pair_width-1:0]    word_i,
    input logic [2*t0_decode_pkg::reg_size-1:0]    pair_o,
    input logic [t0_decode_pkg::pair_addr_w-1:0]   addr_o,
    input logic                                    valid_o,
    input logic                                    poly_done_o
);
    import t0_decode_pkg::*;

    // Number of assertion failures so far that the testbench reads
    int fail_count = 0;

    // Pairs seen on the output modulo 128 since reset or zeroize
    logic [pair_addr_w-1:0] out_count;

    // Decoded coefficient is (4096 - field) mod q in sub mode and (4096 + field) mod q otherwise
    function automatic logic [reg_size-1:0] expect_coeff(
        input logic [mldsa_d-1:0] field,
        input logic               sub
    );
        int value;
        if (sub) begin
            value = 4096 - int'(field);
            if (value < 0) begin
                value = value + int'(mldsa_q);
            end
        end else begin
            value = 4096 + int'(field);
            if (value >= int'(mldsa_q)) begin
                value = value - int'(mldsa_q);
            end
        end
        return value[reg_size-1:0];
    endfunction

    // ------------------------------
    // Output address model
    // ------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_count <= '0;
        end else if (zeroize_i) begin
            out_count <= '0;
        end else if (valid_o) begin
            out_count <= out_count + pair_addr_w'(1);
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    // Output strobe is the input strobe two edges later, unless zeroize dropped the word
    valid_latency_a: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o == ($past(valid_i, 2) && !$past(zeroize_i, 1) && !$past(zeroize_i, 2)))
        else begin
            fail_count = fail_count + 1;
            $error("[ERROR] valid_o is %h, expected %h", $sampled(valid_o),
                $past(valid_i, 2) && !$past(zeroize_i, 1) && !$past(zeroize_i, 2));
        end

    // Lower half holds lane 0, decoded from the lower field of the word sent earlier
    pair_lo_a: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o |-> pair_o[reg_size-1:0] ==
            expect_coeff($past(word_i[mldsa_d-1:0], 2), $past(sub_i, 2)))
        else begin
            fail_count = fail_count + 1;
            $error("[ERROR] pair_o lower half is %h, expected %h",
                $sampled(pair_o[reg_size-1:0]),
                expect_coeff($past(word_i[mldsa_d-1:0], 2), $past(sub_i, 2)));
        end

    // Upper half holds lane 1 from the upper field
    pair_hi_a: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o |-> pair_o[2*reg_size-1:reg_size] ==
            expect_coeff($past(word_i[pair_width-1:mldsa_d], 2), $past(sub_i, 2)))
        else begin
            fail_count = fail_count + 1;
            $error("[ERROR] pair_o upper half is %h, expected %h",
                $sampled(pair_o[2*reg_size-1:reg_size]),
                expect_coeff($past(word_i[pair_width-1:mldsa_d], 2), $past(sub_i, 2)));
        end

    pair_addr_a: assert property (@(posedge clk) disable iff (!reset_n)
        valid_o |-> addr_o == out_count)
        else begin
            fail_count = fail_count + 1;
            $error("[ERROR] addr_o is %h, expected %h", $sampled(addr_o), $sampled(out_count));
        end

    // Pair 127 closes a polynomial and is the only one that raises the flag
    poly_done_a: assert property (@(posedge clk) disable iff (!reset_n)
        poly_done_o == (valid_o && addr_o == pair_addr_w'(coeff_pairs - 1)))
        else begin
            fail_count = fail_count + 1;
            $error("[ERROR] poly_done_o is %h, expected %h with addr_o %h",
                $sampled(poly_done_o),
                $sampled(valid_o) && $sampled(addr_o) == pair_addr_w'(coeff_pairs - 1),
                $sampled(addr_o));
        end

    // Words in flight at a zeroize never come out
    zeroize_drop_a: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> !valid_o ##1 !valid_o)
        else begin
            fail_count = fail_count + 1;
            $error("[ERROR] valid_o is %h shortly after a zeroize, expected 0",
                $sampled(valid_o));
        end

    reset_state_a: assert property (@(posedge clk)
        $rose(reset_n) |-> (!valid_o && !poly_done_o && addr_o == '0))
        else begin
            fail_count = fail_count + 1;
            $error("[ERROR] after reset valid_o %h poly_done_o %h addr_o %h, all expected 0",
                $sampled(valid_o), $sampled(poly_done_o), $sampled(addr_o));
        end

endmodule

// ==== verif/skdecode_t0_tb.sv ====
`timescale 1ns/10ps

module skdecode_t0_tb;
    import t0_decode_pkg::*;

    localparam int clk_period   = 20;
    localparam int edge_words   = 6;
    localparam int rand_words   = 20;
    localparam int burst_slots  = 16;
    localparam int addr_words   = 300;
    localparam int zero_words   = 12;
    localparam int drain_cycles = 8;
    localparam int test_count   = 5;

    // Every word and idle slot of the run, plus drain and reset cycles
    localparam int run_cycles = 2 * (edge_words + rand_words) + burst_slots + addr_words
                              + zero_words + test_count * drain_cycles + 16;

    // Watchdog allows twice the expected run time
    localparam int watchdog_time = 2 * run_cycles * clk_period;

    logic                     clk;
    logic                     reset_n;
    logic                     zeroize_i;
    logic                     valid_i;
    logic                     sub_i;
    logic [pair_width-1:0]    word_i;
    logic [2*reg_size-1:0]    pair_o;
    logic [pair_addr_w-1:0]   addr_o;
    logic                     valid_o;
    logic                     poly_done_o;

    logic [31:0]              rng_state = 32'h5eb8_fccf;
    logic [mldsa_d-1:0]       edge_fields [edge_words] = '{0, 1, 4095, 4096, 4097, 8191};
    logic [burst_slots-1:0]   burst_pattern = 16'b1110_1100_1011_0001;
    int                       fails_before = 0;
    int                       tests_done = 0;
    int                       total_fails;

    skdecode_t0 skdecode_t0_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .valid_i     (valid_i),
        .sub_i       (sub_i),
        .word_i      (word_i),
        .pair_o      (pair_o),
        .addr_o      (addr_o),
        .valid_o     (valid_o),
        .poly_done_o (poly_done_o)
    );

    bind skdecode_t0 skdecode_t0_chk skdecode_t0_chk_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .valid_i     (valid_i),
        .sub_i       (sub_i),
        .word_i      (word_i),
        .pair_o      (pair_o),
        .addr_o      (addr_o),
        .valid_o     (valid_o),
        .poly_done_o (poly_done_o)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int assertion_failures();
        return skdecode_t0_inst.skdecode_t0_chk_inst.fail_count;
    endfunction

    task automatic send_word(input logic sub, input logic [mldsa_d-1:0] hi,
                             input logic [mldsa_d-1:0] lo);
        @(posedge clk);
        zeroize_i <= 1'b0;
        valid_i   <= 1'b1;
        sub_i     <= sub;
        word_i    <= {hi, lo};
    endtask

    // Random word with both fields taken from one xorshift step
    task automatic send_random(input logic sub);
        rng_state = xorshift32(rng_state);
        send_word(sub, rng_state[2*mldsa_d-1:mldsa_d], rng_state[mldsa_d-1:0]);
    endtask

    // Zeroize arrives together with a fresh word, which must be dropped as well
    task automatic send_with_zeroize();
        rng_state = xorshift32(rng_state);
        @(posedge clk);
        zeroize_i <= 1'b1;
        valid_i   <= 1'b1;
        sub_i     <= rng_state[31];
        word_i    <= rng_state[pair_width-1:0];
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            zeroize_i <= 1'b0;
            valid_i   <= 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        valid_i <= 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    // Counts are read half a cycle after the last edge once its assertions have settled
    task automatic report_test(input string name);
        int now_fails;
        @(negedge clk);
        now_fails = assertion_failures();
        tests_done = tests_done + 1;
        $display("Test %0s finished with %0d assertion failures", name, now_fails - fails_before);
        fails_before = now_fails;
    endtask

    // ------------------------------
    // Clock and watchdog
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_time);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_time);
        $display("Errors found");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        valid_i   = 1'b0;
        sub_i     = 1'b0;
        word_i    = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        idle_cycles(2);

        // Edge fields pair up in reverse so each lane sees every edge value
        for (int i = 0; i < edge_words; i++) begin
            send_word(1'b1, edge_fields[edge_words-1-i], edge_fields[i]);
        end
        for (int i = 0; i < rand_words; i++) begin
            send_random(1'b1);
        end
        idle_cycles(drain_cycles);
        report_test("subtract_mode");

        for (int i = 0; i < edge_words; i++) begin
            send_word(1'b0, edge_fields[edge_words-1-i], edge_fields[i]);
        end
        for (int i = 0; i < rand_words; i++) begin
            send_random(1'b0);
        end
        idle_cycles(drain_cycles);
        report_test("add_mode");

        // Bursts with gaps where the mode flips from word to word
        for (int i = 0; i < burst_slots; i++) begin
            if (burst_pattern[burst_slots-1-i]) begin
                send_random(i[0]);
            end else begin
                idle_cycles(1);
            end
        end
        idle_cycles(drain_cycles);
        report_test("latency_order");

        for (int i = 0; i < addr_words; i++) begin
            send_random(rng_state[31]);
        end
        idle_cycles(drain_cycles);
        report_test("addressing");

        // A fresh reset comes first and then a burst cut by a zeroize pulse
        apply_reset();
        idle_cycles(2);
        for (int i = 0; i < 5; i++) begin
            send_random(1'b1);
        end
        send_with_zeroize();
        for (int i = 0; i < 6; i++) begin
            send_random(1'b0);
        end
        idle_cycles(drain_cycles);
        report_test("reset_zeroize");

        total_fails = assertion_failures();
        $display("Tests run: %0d, assertion failures: %0d", tests_done, total_fails);
        if (total_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hdl/t0_decode_pkg.sv
hdl/t0_unpack.sv
hdl/coeff_pair_pack.sv
hdl/skdecode_t0.sv
verif/skdecode_t0_chk.sv
verif/skdecode_t0_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the t0 decoder testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module skdecode_t0_tb \
    -f src.f \
    -o skdecode_t0_sim

# Assertion failures must not stop the run early, so the closing count is printed
status=0
./obj_dir/skdecode_t0_sim +verilator+error+limit+100000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "No errors" sim.log; then
    echo "Simulation did not complete, exit status $status"
    exit 1
fi
echo "Simulation passed"
